// ==== spi_mem_pkg.sv ====
// SPI memory bridge definitions
`default_nettype none

package spi_mem_pkg;

    localparam int ADDR_W       = 4;
    localparam int DATA_W       = 8;
    localparam int MEM_DEPTH    = 16;
    localparam int CMD_READ_BIT = 7;
    localparam int SYNC_STAGES  = 3;
    localparam int N_PORTS      = 2;

    typedef logic [ADDR_W-1:0]          addr_t;
    typedef logic [DATA_W-1:0]          data_t;
    typedef logic [$clog2(N_PORTS)-1:0] port_sel_t;

    // Arbiter port numbers
    localparam port_sel_t ENG_PORT  = port_sel_t'(0);
    localparam port_sel_t HOST_PORT = port_sel_t'(1);

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        WR_DATA,
        RD_FETCH,
        RD_WAIT,
        RD_SEND
    } engine_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ACCESS,
        ARB_ACK,
        ARB_RELEASE
    } arb_state_t;

endpackage

`default_nettype wire

// ==== spi_byte_slave.sv ====
// SPI mode-0 byte slave
`default_nettype none

module spi_byte_slave
    import spi_mem_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  sclk_i,
    input  logic  cs_n_i,
    input  logic  mosi_i,
    output logic  miso_o,
    input  data_t tx_data_i,
    input  logic  tx_valid_i,
    output logic  tx_ready_o,
    output data_t rx_data_o,
    output logic  rx_valid_o,
    input  logic  rx_ready_i
);

    logic [SYNC_STAGES-1:0] sclk_sync;
    logic                   sclk_rise;
    logic                   sclk_fall;

    logic [2:0] rx_cnt;
    data_t      rx_shift;
    logic       rx_last;
    logic       rx_load;

    logic [2:0] tx_cnt;
    data_t      tx_shift;
    data_t      tx_hold;
    logic       tx_held;
    logic       tx_take;
    logic       tx_boundary;

    // sclk enters at bit 0 and the oldest sample sits at the top
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sclk_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk_i};
        end
    end

    assign sclk_rise = sclk_sync[SYNC_STAGES-2] & ~sclk_sync[SYNC_STAGES-1];
    assign sclk_fall = ~sclk_sync[SYNC_STAGES-2] & sclk_sync[SYNC_STAGES-1];

    assign rx_last = !cs_n_i && sclk_rise && (rx_cnt == 3'd7);
    // A full byte is dropped while the previous one is still pending
    assign rx_load = rx_last && (!rx_valid_o || rx_ready_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_cnt     <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            if (rx_valid_o && rx_ready_i) begin
                rx_valid_o <= 1'b0;
            end
            if (rx_load) begin
                rx_valid_o <= 1'b1;
            end
            if (cs_n_i) begin
                rx_cnt <= '0;
            end else if (sclk_rise) begin
                rx_cnt <= rx_cnt + 3'd1;
            end
        end
    end

    // MSB first
    always_ff @(posedge clk_i) begin
        if (!cs_n_i && sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_i};
        end
        if (rx_load) begin
            rx_data_o <= {rx_shift[6:0], mosi_i};
        end
    end

    assign tx_take     = tx_valid_i && tx_ready_o;
    assign tx_boundary = !cs_n_i && sclk_fall && (tx_cnt == 3'd7);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_cnt     <= '0;
            tx_shift   <= '0;
            tx_held    <= 1'b0;
            tx_ready_o <= 1'b0;
        end else if (cs_n_i) begin
            tx_cnt     <= '0;
            tx_shift   <= '0;
            tx_held    <= 1'b0;
            tx_ready_o <= 1'b0;
        end else begin
            if (sclk_fall) begin
                tx_cnt <= tx_cnt + 3'd1;
                if (tx_boundary) begin
                    // Underrun sends zeros
                    tx_shift <= tx_held ? tx_hold : '0;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
            if (tx_take) begin
                tx_held <= 1'b1;
            end else if (tx_boundary) begin
                tx_held <= 1'b0;
            end
            tx_ready_o <= !(tx_take || (tx_held && !tx_boundary));
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_take) begin
            tx_hold <= tx_data_i;
        end
    end

    assign miso_o = tx_shift[7];

endmodule

`default_nettype wire

// ==== spi_cmd_engine.sv ====
// SPI command engine
`default_nettype none

module spi_cmd_engine
    import spi_mem_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  cs_n_i,
    input  logic  rx_valid_i,
    input  data_t rx_data_i,
    output logic  rx_ready_o,
    output logic  tx_valid_o,
    output data_t tx_data_o,
    input  logic  tx_ready_i,
    output logic  mem_req_o,
    output logic  mem_we_o,
    output addr_t mem_addr_o,
    output data_t mem_wdata_o,
    input  logic  mem_ack_i,
    input  data_t mem_rdata_i
);

    engine_state_t state;
    addr_t         cur_addr;
    logic          port_free;
    logic          mem_done;

    function automatic addr_t next_addr(input addr_t a);
        next_addr = (a == addr_t'(MEM_DEPTH - 1)) ? '0 : a + addr_t'(1);
    endfunction

    // No new request until the last one has fully released
    assign port_free = !mem_req_o && !mem_ack_i;
    assign mem_done  = mem_req_o && mem_ack_i;

    // Writes hold the byte back while the memory port is busy
    assign rx_ready_o = (state != WR_DATA) || port_free;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= IDLE;
            mem_req_o  <= 1'b0;
            tx_valid_o <= 1'b0;
        end else begin
            // Four-phase release runs even after the frame ends
            if (mem_done) begin
                mem_req_o <= 1'b0;
            end
            if (cs_n_i) begin
                state      <= IDLE;
                tx_valid_o <= 1'b0;
            end else begin
                case (state)
                    IDLE: begin
                        state <= CMD;
                    end
                    CMD: begin
                        if (rx_valid_i) begin
                            state <= rx_data_i[CMD_READ_BIT] ? RD_FETCH : WR_DATA;
                        end
                    end
                    WR_DATA: begin
                        if (rx_valid_i && rx_ready_o) begin
                            mem_req_o <= 1'b1;
                        end
                    end
                    RD_FETCH: begin
                        if (port_free) begin
                            mem_req_o <= 1'b1;
                            state     <= RD_WAIT;
                        end
                    end
                    RD_WAIT: begin
                        if (mem_done) begin
                            tx_valid_o <= 1'b1;
                            state      <= RD_SEND;
                        end
                    end
                    RD_SEND: begin
                        // Next fetch starts as soon as the slave holds this byte
                        if (tx_ready_i) begin
                            tx_valid_o <= 1'b0;
                            state      <= RD_FETCH;
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // Address and payload registers
    always_ff @(posedge clk_i) begin
        if (!cs_n_i) begin
            if (state == CMD && rx_valid_i) begin
                cur_addr <= rx_data_i[ADDR_W-1:0];
            end
            if (state == WR_DATA) begin
                if (rx_valid_i && rx_ready_o) begin
                    mem_we_o    <= 1'b1;
                    mem_addr_o  <= cur_addr;
                    mem_wdata_o <= rx_data_i;
                end
                if (mem_done) begin
                    cur_addr <= next_addr(cur_addr);
                end
            end
            if (state == RD_FETCH && port_free) begin
                mem_we_o   <= 1'b0;
                mem_addr_o <= cur_addr;
            end
            if (state == RD_WAIT && mem_done) begin
                tx_data_o <= mem_rdata_i;
                cur_addr  <= next_addr(cur_addr);
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
// Round-robin memory arbiter
`default_nettype none

module mem_arbiter
    import spi_mem_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  eng_req_i,
    input  logic  eng_we_i,
    input  addr_t eng_addr_i,
    input  data_t eng_wdata_i,
    output logic  eng_ack_o,
    output data_t eng_rdata_o,
    input  logic  host_req_i,
    input  logic  host_we_i,
    input  addr_t host_addr_i,
    input  data_t host_wdata_i,
    output logic  host_ack_o,
    output data_t host_rdata_o,
    output logic  ram_we_o,
    output addr_t ram_addr_o,
    output data_t ram_wdata_o,
    input  data_t ram_rdata_i
);

    arb_state_t         state;
    // Also selects the port in service while a transaction runs
    port_sel_t          last_served;
    port_sel_t          pick;
    logic [N_PORTS-1:0] req_vec;
    logic [N_PORTS-1:0] ack_q;
    data_t              rdata_q [N_PORTS];
    logic               host_sel;

    assign req_vec = {host_req_i, eng_req_i};

    // Prefer the port that was not served last
    assign pick = req_vec[~last_served] ? ~last_served : last_served;

    assign host_sel    = (last_served == HOST_PORT);
    assign ram_we_o    = (state == ARB_ACCESS) && (host_sel ? host_we_i : eng_we_i);
    assign ram_addr_o  = host_sel ? host_addr_i : eng_addr_i;
    assign ram_wdata_o = host_sel ? host_wdata_i : eng_wdata_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state       <= ARB_IDLE;
            last_served <= HOST_PORT;
            ack_q       <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (|req_vec) begin
                        last_served <= pick;
                        state       <= ARB_ACCESS;
                    end
                end
                ARB_ACCESS: begin
                    state <= ARB_ACK;
                end
                ARB_ACK: begin
                    ack_q[last_served] <= 1'b1;
                    state              <= ARB_RELEASE;
                end
                ARB_RELEASE: begin
                    if (!req_vec[last_served]) begin
                        ack_q[last_served] <= 1'b0;
                        state              <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // RAM read data is valid one cycle after the access
    always_ff @(posedge clk_i) begin
        if (state == ARB_ACK) begin
            rdata_q[last_served] <= ram_rdata_i;
        end
    end

    assign eng_ack_o    = ack_q[ENG_PORT];
    assign host_ack_o   = ack_q[HOST_PORT];
    assign eng_rdata_o  = rdata_q[ENG_PORT];
    assign host_rdata_o = rdata_q[HOST_PORT];

endmodule

`default_nettype wire

// ==== byte_ram.sv ====
// Byte-wide single-port RAM
`default_nettype none

module byte_ram
    import spi_mem_pkg::*;
(
    input  logic  clk_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  data_t wdata_i,
    output data_t rdata_o
);

    data_t mem [MEM_DEPTH];

    // Read returns the old word during a write
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

// ==== spi_mem_top.sv ====
// SPI to memory bridge top
`default_nettype none

module spi_mem_top
    import spi_mem_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  sclk_i,
    input  logic  cs_n_i,
    input  logic  mosi_i,
    output logic  miso_o,
    input  logic  host_req_i,
    input  logic  host_we_i,
    input  addr_t host_addr_i,
    input  data_t host_wdata_i,
    output logic  host_ack_o,
    output data_t host_rdata_o
);

    data_t rx_data;
    logic  rx_valid;
    logic  rx_ready;
    data_t tx_data;
    logic  tx_valid;
    logic  tx_ready;

    logic  eng_req;
    logic  eng_we;
    addr_t eng_addr;
    data_t eng_wdata;
    logic  eng_ack;
    data_t eng_rdata;

    logic  ram_we;
    addr_t ram_addr;
    data_t ram_wdata;
    data_t ram_rdata;

    spi_byte_slave i_spi_slave (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .sclk_i     (sclk_i),
        .cs_n_i     (cs_n_i),
        .mosi_i     (mosi_i),
        .miso_o     (miso_o),
        .tx_data_i  (tx_data),
        .tx_valid_i (tx_valid),
        .tx_ready_o (tx_ready),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid),
        .rx_ready_i (rx_ready)
    );

    spi_cmd_engine i_cmd_engine (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cs_n_i      (cs_n_i),
        .rx_valid_i  (rx_valid),
        .rx_data_i   (rx_data),
        .rx_ready_o  (rx_ready),
        .tx_valid_o  (tx_valid),
        .tx_data_o   (tx_data),
        .tx_ready_i  (tx_ready),
        .mem_req_o   (eng_req),
        .mem_we_o    (eng_we),
        .mem_addr_o  (eng_addr),
        .mem_wdata_o (eng_wdata),
        .mem_ack_i   (eng_ack),
        .mem_rdata_i (eng_rdata)
    );

    mem_arbiter i_arbiter (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .eng_req_i    (eng_req),
        .eng_we_i     (eng_we),
        .eng_addr_i   (eng_addr),
        .eng_wdata_i  (eng_wdata),
        .eng_ack_o    (eng_ack),
        .eng_rdata_o  (eng_rdata),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .ram_we_o     (ram_we),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata),
        .ram_rdata_i  (ram_rdata)
    );

    byte_ram i_ram (
        .clk_i   (clk_i),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_spi_mem_chk.sv ====
// Memory port handshake checker
`default_nettype none

module tb_spi_mem_chk (
    input logic clk_i,
    input logic rst_i,
    input logic host_req_i,
    input logic host_ack_i,
    input logic eng_ack_i
);

    // Ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(host_ack_i) |-> host_req_i)
        else $error("host_ack_o rose while host_req_i was low");

    ack_held: assert property (@(posedge clk_i) disable iff (rst_i)
        host_ack_i && host_req_i |=> host_ack_i)
        else $error("host_ack_o fell before host_req_i was released");

    // One grant at a time
    ack_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(eng_ack_i && host_ack_i))
        else $error("engine and host acks were high together");

endmodule

`default_nettype wire

// ==== tb_spi_mem.sv ====
// SPI memory bridge testbench
`default_nettype none

module tb_spi_mem
    import spi_mem_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int SPI_HALF        = 16;
    localparam int MAX_LEN         = 4;
    localparam int N_ROWS          = 14;
    localparam int ROW_MAX_CYCLES  = (MAX_LEN + 2) * 16 * SPI_HALF;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_ROWS * ROW_MAX_CYCLES + 1000;
    localparam int SEED            = 81484;

    typedef enum logic [2:0] {
        SPI_WRITE,
        SPI_READ,
        HOST_WRITE,
        HOST_READ,
        SPI_ABORT
    } kind_t;

    typedef data_t [MAX_LEN-1:0] bytes_t;

    // busy_host runs random host traffic on words 8 to 15 during the frame
    typedef struct packed {
        kind_t      kind;
        addr_t      addr;
        logic [2:0] len;
        logic       busy_host;
        bytes_t     data;
    } row_t;

    logic  clk_i;
    logic  rst_i;
    logic  sclk_i;
    logic  cs_n_i;
    logic  mosi_i;
    logic  miso_o;
    logic  host_req_i;
    logic  host_we_i;
    addr_t host_addr_i;
    data_t host_wdata_i;
    logic  host_ack_o;
    data_t host_rdata_o;

    data_t  model_mem [MEM_DEPTH];
    logic   model_known [MEM_DEPTH];
    row_t   rows [N_ROWS];
    bytes_t miso_bytes;
    logic   spi_busy;
    int     errors;
    int     checks;

    spi_mem_top i_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .sclk_i       (sclk_i),
        .cs_n_i       (cs_n_i),
        .mosi_i       (mosi_i),
        .miso_o       (miso_o),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o)
    );

    bind spi_mem_top tb_spi_mem_chk i_chk (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .host_req_i (host_req_i),
        .host_ack_i (host_ack_o),
        .eng_ack_i  (eng_ack)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic report_mismatch(input string name, input data_t exp, input data_t got);
        errors++;
        $display("Error at time %0t: %s expected %02h, got %02h", $time, name, exp, got);
    endtask

    // One full four-phase transaction on the host port
    task automatic host_access(input logic we, input addr_t addr, input data_t wdata,
                               output data_t rdata);
        @(posedge clk_i);
        host_req_i   <= 1'b1;
        host_we_i    <= we;
        host_addr_i  <= addr;
        host_wdata_i <= wdata;
        do @(negedge clk_i); while (!host_ack_o);
        rdata = host_rdata_o;
        @(posedge clk_i);
        host_req_i <= 1'b0;
        do @(negedge clk_i); while (host_ack_o);
    endtask

    // Mode 0 frame with MISO captured as each rising sclk is driven
    task automatic spi_frame(input data_t cmd, input int len, input int last_bits,
                             input bytes_t wr);
        data_t tx;
        data_t rx;
        int    nbits;
        @(posedge clk_i);
        miso_bytes = '0;
        cs_n_i <= 1'b0;
        for (int b = 0; b <= len; b++) begin
            if (b == 0) begin
                tx = cmd;
            end else begin
                tx = wr[b-1];
            end
            nbits = (b == len && b != 0) ? last_bits : 8;
            rx    = '0;
            for (int i = 0; i < nbits; i++) begin
                mosi_i <= tx[7-i];
                wait_cycles(SPI_HALF);
                sclk_i <= 1'b1;
                rx = {rx[6:0], miso_o};
                wait_cycles(SPI_HALF);
                sclk_i <= 1'b0;
            end
            if (b > 0) begin
                miso_bytes[b-1] = rx;
            end
        end
        wait_cycles(SPI_HALF);
        cs_n_i <= 1'b1;
        wait_cycles(2 * SPI_HALF);
    endtask

    task automatic host_traffic();
        addr_t a;
        data_t d;
        data_t r;
        logic  we;
        a  = addr_t'(8 + ($urandom % 8));
        we = 1'($urandom % 2);
        d  = 8'($urandom);
        wait_cycles(int'($urandom % 5));
        host_access(we, a, d, r);
        if (we) begin
            model_mem[a]   = d;
            model_known[a] = 1'b1;
        end else if (model_known[a]) begin
            checks++;
            if (r !== model_mem[a]) begin
                report_mismatch("host_rdata_o", model_mem[a], r);
            end
        end
    endtask

    task automatic spi_with_traffic(input data_t cmd, input int len, input bytes_t wr,
                                    input logic busy_host);
        if (busy_host) begin
            spi_busy = 1'b1;
            fork
                begin
                    spi_frame(cmd, len, 8, wr);
                    spi_busy = 1'b0;
                end
                begin
                    while (spi_busy) begin
                        host_traffic();
                    end
                end
            join
        end else begin
            spi_frame(cmd, len, 8, wr);
        end
    endtask

    task automatic run_row(input row_t row);
        data_t  cmd;
        data_t  r;
        addr_t  a;
        bytes_t dummy;
        case (row.kind)
            SPI_WRITE: begin
                // Bits 6:4 of the command carry random filler
                cmd = {1'b0, 3'($urandom), row.addr};
                spi_with_traffic(cmd, int'(row.len), row.data, row.busy_host);
                for (int k = 0; k < int'(row.len); k++) begin
                    a              = addr_t'(row.addr + k);
                    model_mem[a]   = row.data[k];
                    model_known[a] = 1'b1;
                end
            end
            SPI_READ: begin
                cmd   = {1'b1, 3'($urandom), row.addr};
                dummy = $urandom;
                spi_with_traffic(cmd, int'(row.len), dummy, row.busy_host);
                for (int k = 0; k < int'(row.len); k++) begin
                    a = addr_t'(row.addr + k);
                    if (model_known[a]) begin
                        checks++;
                        if (miso_bytes[k] !== model_mem[a]) begin
                            report_mismatch("miso_o", model_mem[a], miso_bytes[k]);
                        end
                    end
                end
            end
            SPI_ABORT: begin
                // Half a data byte, then cs_n_i rises
                cmd = {1'b0, 3'($urandom), row.addr};
                spi_frame(cmd, 1, 4, row.data);
            end
            HOST_WRITE: begin
                for (int k = 0; k < int'(row.len); k++) begin
                    a = addr_t'(row.addr + k);
                    host_access(1'b1, a, row.data[k], r);
                    model_mem[a]   = row.data[k];
                    model_known[a] = 1'b1;
                end
            end
            HOST_READ: begin
                for (int k = 0; k < int'(row.len); k++) begin
                    a = addr_t'(row.addr + k);
                    host_access(1'b0, a, 8'h00, r);
                    if (model_known[a]) begin
                        checks++;
                        if (r !== model_mem[a]) begin
                            report_mismatch("host_rdata_o", model_mem[a], r);
                        end
                    end
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic load_rows();
        // kind, start address, length, host traffic, data with byte 0 lowest
        rows[0]  = '{HOST_READ,  4'd5,  3'd1, 1'b0, 32'h00000000};
        rows[1]  = '{SPI_WRITE,  4'd2,  3'd4, 1'b0, 32'hD4C3B2A1};
        rows[2]  = '{HOST_READ,  4'd2,  3'd4, 1'b0, 32'h00000000};
        // Wraps from 15 to 0
        rows[3]  = '{HOST_WRITE, 4'd14, 3'd4, 1'b0, 32'h44332211};
        rows[4]  = '{SPI_READ,   4'd14, 3'd4, 1'b0, 32'h00000000};
        rows[5]  = '{HOST_WRITE, 4'd8,  3'd4, 1'b0, 32'h8D7C6B5A};
        rows[6]  = '{SPI_WRITE,  4'd4,  3'd4, 1'b1, 32'hE7C65A39};
        rows[7]  = '{SPI_READ,   4'd0,  3'd4, 1'b1, 32'h00000000};
        rows[8]  = '{SPI_READ,   4'd4,  3'd4, 1'b1, 32'h00000000};
        rows[9]  = '{SPI_ABORT,  4'd6,  3'd1, 1'b0, 32'h000000FF};
        rows[10] = '{SPI_READ,   4'd5,  3'd3, 1'b0, 32'h00000000};
        rows[11] = '{SPI_WRITE,  4'd6,  3'd2, 1'b0, 32'h00009C0F};
        rows[12] = '{HOST_READ,  4'd6,  3'd2, 1'b0, 32'h00000000};
        rows[13] = '{HOST_READ,  4'd8,  3'd4, 1'b0, 32'h00000000};
    endtask

    initial begin
        void'($urandom(SEED));
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        sclk_i       = 1'b0;
        cs_n_i       = 1'b1;
        mosi_i       = 1'b0;
        host_req_i   = 1'b0;
        host_we_i    = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;
        spi_busy     = 1'b0;
        errors       = 0;
        checks       = 0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model_known[i] = 1'b0;
        end
        load_rows();
        wait_cycles(RESET_CYCLES);
        rst_i <= 1'b0;
        wait_cycles(2);
        @(negedge clk_i);
        checks += 2;
        if (host_ack_o !== 1'b0) begin
            report_mismatch("host_ack_o", 8'h00, {7'b0, host_ack_o});
        end
        if (miso_o !== 1'b0) begin
            report_mismatch("miso_o", 8'h00, {7'b0, miso_o});
        end
        for (int n = 0; n < N_ROWS; n++) begin
            run_row(rows[n]);
        end
        wait_cycles(8);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("Watchdog expired: the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
spi_mem_pkg.sv
spi_byte_slave.sv
spi_cmd_engine.sv
mem_arbiter.sv
byte_ram.sv
spi_mem_top.sv
tb_spi_mem_chk.sv
tb_spi_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_spi_mem
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
